// ==== smu_patterns.txt ====
# kind addr data expected, hex; W write, R read-compare, S SMUCR write with pulse check
# P source pulse (addr = cycles), H hold source level, C output check (addr = output id)
R 000 00000000 03500001
R 004 00000000 00000a01
R 008 00000000 00000002
R 00c 00000000 00010000
R 070 00000000 00005a5a
R 024 00000000 00000001
R 020 00000000 00000007
R 050 00000000 80000000
R 060 00000000 00000000
R 054 00000000 80000000
R 064 00000000 00000000
R 058 00000000 00000000
R 06c 00000000 00000000
R 010 00000000 00000001
W 024 ffffffea 00000000
R 024 00000000 0000000a
C 000 00000000 0000000a
W 020 fffffffd 00000000
R 020 00000000 00000005
C 001 00000000 00000005
W 050 12345677 00000000
R 050 00000000 12345674
W 064 deadbeef 00000000
R 064 00000000 deadbeef
C 002 00000000 12345674
C 005 00000000 deadbeef
W 058 aaaaaaaa 00000000
R 058 00000000 00000000
C 006 00000000 00000000
S 014 0000003c 00000001
S 014 0000003d 00000000
S 014 1234563c 00000001
W 010 00000001 00000000
R 010 00000000 00000000
P 002 00000008 00000000
R 010 00000000 00000008
W 010 00000008 00000000
R 010 00000000 00000000
H 000 00000010 00000000
W 010 00000010 00000000
R 010 00000000 00000010
H 000 00000000 00000000
W 010 00000010 00000000
R 010 00000000 00000000
R 080 00000000 c0de0000
C 00a 00000000 00000001
C 00b 00000000 00000000
R 0ac 00000000 c0de0001
C 00a 00000000 00000002
C 00b 00000000 00000003
R 0dc 00000000 c0de0002
C 00b 00000000 00000007
R 0e4 00000000 c0de0003
C 00a 00000000 00000008
R 110 00000000 c0de0004
C 00a 00000000 00000010
C 00b 00000000 00000004
R 13c 00000000 c0de0005
C 00a 00000000 00000020
W 128 cafef00d 00000000
C 00a 00000000 00000020
C 00b 00000000 00000002
C 00c 00000000 00000001
C 00d 00000000 cafef00d
R 140 00000000 00000000
C 00a 00000000 00000000
R 160 00000000 00000000
C 00a 00000000 00000000
R 180 00000000 00000000
C 00a 00000000 00000000
R 040 00000000 00000000

// ==== filelist.f ====
+incdir+.
smu_pkg.sv
smu_apb_decode.sv
smu_sys_regs.sv
smu_reset_status.sv
smu_rst_vec_regs.sv
smu_pcs_port.sv
smu_apb_top.sv
smu_apb_chk.sv
tb_smu_apb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_smu_apb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass message"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_smu_apb.sv ====
`timescale 1ns/1ps
`include "smu_defs.svh"

module tb_smu_apb;
	import smu_pkg::*;

	localparam int PULSE_TIMEOUT = 16;                  // Cycles to wait for smu_sw_rst

	logic                                       pclk;
	logic                                       apor_rstn;
	logic                                       psel;
	logic                                       penable;
	logic                                       pwrite;
	logic [12:2]                                paddr;
	logic [`SMU_DATA_W-1:0]                     pwdata;
	logic [`SMU_PCS_MAX-1:0][`SMU_DATA_W-1:0]   pcs_rdata;
	logic [`SMU_RST_SRC_W-1:0]                  pcs0_reset_source;
	logic [`SMU_DATA_W-1:0]                     prdata;
	logic                                       pready;
	logic                                       pslverr;
	pcs_req_t                                   pcs_req;
	logic                                       smu_sw_rst;
	logic [`SMU_CLKR_W-1:0]                     system_clock_ratio;
	logic [`SMU_CER_W-1:0]                      clk_en;
	hart_vecs_t                                 core_reset_vectors;

	int unsigned        errors;
	pcs_req_t           last_req;                       // Seen in the last access phase
	logic [31:0]        last_rdata;
	logic [31:0]        setup_rdata;                    // Seen in the last setup phase

	smu_apb_top #(.NHART(2), .PCS_NUM(6)) u_dut (.*);

	initial pclk = 1'b0;
	always #5 pclk = ~pclk;

	// ====================
	// Bus and source drivers
	// ====================
	task automatic release_bus();
		psel    = 1'b0;
		penable = 1'b0;
		pwrite  = 1'b0;
	endtask

	// Ends in the access phase so a following transfer runs back to back
	task automatic apb_xfer(input logic wr, input logic [12:0] addr, input logic [31:0] wdata);
		@(negedge pclk);
		psel    = 1'b1;                                 // Setup phase
		penable = 1'b0;
		pwrite  = wr;
		paddr   = addr[12:2];
		pwdata  = wdata;
		#1;
		setup_rdata = prdata;
		@(negedge pclk);
		penable = 1'b1;                                 // Access phase
		#1;
		last_rdata = prdata;
		last_req   = pcs_req;
	endtask

	task automatic pulse_source(input int cycles, input logic [`SMU_RST_SRC_W-1:0] mask);
		@(negedge pclk);
		release_bus();
		pcs0_reset_source = mask;
		repeat (cycles) @(negedge pclk);
		pcs0_reset_source = '0;
	endtask

	task automatic hold_source(input logic [`SMU_RST_SRC_W-1:0] mask);
		@(negedge pclk);
		release_bus();
		pcs0_reset_source = mask;                       // Stays until the next change
	endtask

	task automatic report_mismatch(input string what, input logic [12:0] addr,
			input logic [31:0] exp, input logic [31:0] act);
		errors++;
		$display("[ERROR] %0t: %s at 0x%03h, expected 0x%08h, got 0x%08h",
			$time, what, addr, exp, act);
	endtask

	// Output ids 2..9 are the 32-bit words of core_reset_vectors
	function automatic logic [31:0] output_value(input logic [12:0] id);
		logic [255:0] flat;
		flat = core_reset_vectors;
		if (id >= 13'h002 && id <= 13'h009) begin
			return flat[(int'(id) - 2) * 32 +: 32];
		end
		case (id)
			13'h000: return 32'(system_clock_ratio);
			13'h001: return 32'(clk_en);
			13'h00a: return 32'(last_req.sel);
			13'h00b: return 32'(last_req.reg_idx);
			13'h00c: return 32'(last_req.write);
			13'h00d: return last_req.wdata;
			default: return 32'hdead_dead;
		endcase
	endfunction

	task automatic check_sw_pulse(input logic [12:0] addr, input logic [31:0] wdata,
			input logic expect_pulse);
		int   cyc;
		int   width;
		logic seen;
		cyc   = 0;
		width = 0;
		seen  = 1'b0;
		apb_xfer(1'b1, addr, wdata);
		@(negedge pclk);
		release_bus();
		while (!seen && cyc < PULSE_TIMEOUT) begin
			if (smu_sw_rst) begin
				seen = 1'b1;
			end else begin
				@(negedge pclk);
				cyc++;
			end
		end
		while (smu_sw_rst && width < PULSE_TIMEOUT) begin
			width++;
			@(negedge pclk);
		end
		if (expect_pulse && !seen) begin
			errors++;
			$display("Software reset pulse missing %0d cycles after SMUCR write of 0x%08h",
				PULSE_TIMEOUT, wdata);
		end else if (expect_pulse && width != 1) begin
			errors++;
			$display("Software reset pulse lasted %0d cycles instead of one", width);
		end else if (!expect_pulse && seen) begin
			errors++;
			$display("Software reset pulse after SMUCR write of 0x%08h, none expected", wdata);
		end
	endtask

	task automatic run_line(input logic [7:0] kind, input logic [12:0] addr,
			input logic [31:0] data, input logic [31:0] expv);
		case (kind)
			"W": apb_xfer(1'b1, addr, data);
			"R": begin
				apb_xfer(1'b0, addr, 32'h0);
				if (setup_rdata !== expv) begin
					report_mismatch("setup read", addr, expv, setup_rdata);
				end
				if (last_rdata !== expv) begin
					report_mismatch("read", addr, expv, last_rdata);
				end
			end
			"C": begin
				if (output_value(addr) !== expv) begin
					report_mismatch("output", addr, expv, output_value(addr));
				end
			end
			"P": pulse_source(int'(addr), data[`SMU_RST_SRC_W-1:0]);
			"H": hold_source(data[`SMU_RST_SRC_W-1:0]);
			"S": check_sw_pulse(addr, data, expv[0]);
			default: begin
				errors++;
				$display("Unknown pattern kind '%c' in smu_patterns.txt", kind);
			end
		endcase
	endtask

	// ====================
	// Main sequence
	// ====================
	initial begin
		int          fd;
		int          n;
		int unsigned total;
		string       line;
		logic [7:0]  kind;
		logic [12:0] addr;
		logic [31:0] data;
		logic [31:0] expv;
		errors            = 0;
		apor_rstn         = 1'b0;
		psel              = 1'b0;
		penable           = 1'b0;
		pwrite            = 1'b0;
		paddr             = '0;
		pwdata            = '0;
		pcs0_reset_source = '0;
		for (int k = 0; k < `SMU_PCS_MAX; k++) begin
			pcs_rdata[k] = 32'hc0de_0000 + 32'(k);      // Window k id
		end
		repeat (4) @(posedge pclk);
		@(negedge pclk);
		apor_rstn = 1'b1;

		fd = $fopen("smu_patterns.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("Could not open smu_patterns.txt for reading");
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				n = $sscanf(line, "%c %h %h %h", kind, addr, data, expv);
				if (n == 4 && kind != "#") begin
					run_line(kind, addr, data, expv);
				end
			end
			$fclose(fd);
		end

		total = errors + u_dut.u_chk.fail_cnt;
		$display("Errors: %0d check(s), %0d assertion(s)", errors, u_dut.u_chk.fail_cnt);
		if (total == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// ==== smu_apb_chk.sv ====
`timescale 1ns/1ps

module smu_apb_chk (
	input  logic                 pclk,
	input  logic                 apor_rstn,
	input  logic                 psel,
	input  logic                 pready,
	input  logic                 pslverr,
	input  logic                 smu_sw_rst,
	input  smu_pkg::pcs_req_t    pcs_req
);

	int unsigned fail_cnt = 0;                          // Read by the testbench

	// Zero-wait slave, never an error response
	a_no_wait: assert property (@(posedge pclk) disable iff (!apor_rstn)
		pready && !pslverr)
		else begin
			fail_cnt++;
			$error("pready low or pslverr high");
		end

	a_sw_rst_one_cycle: assert property (@(posedge pclk) disable iff (!apor_rstn)
		smu_sw_rst |=> !smu_sw_rst)
		else begin
			fail_cnt++;
			$error("smu_sw_rst high on two consecutive cycles");
		end

	a_pcs_sel: assert property (@(posedge pclk) disable iff (!apor_rstn)
		$onehot0(pcs_req.sel) && (psel || pcs_req.sel == '0))
		else begin
			fail_cnt++;
			$error("pcs_sel not one-hot, or set without psel");
		end

endmodule

bind smu_apb_top smu_apb_chk u_chk (
	.pclk       (pclk),
	.apor_rstn  (apor_rstn),
	.psel       (psel),
	.pready     (pready),
	.pslverr    (pslverr),
	.smu_sw_rst (smu_sw_rst),
	.pcs_req    (pcs_req)
);

// ==== smu_apb_top.sv ====
`timescale 1ns/1ps
`include "smu_defs.svh"

module smu_apb_top #(
	parameter int NHART   = 1,                          // 1 ~ 4
	parameter int PCS_NUM = 8                           // 1 ~ 8
) (
	input  logic                                       pclk,
	input  logic                                       apor_rstn,
	input  logic                                       psel,
	input  logic                                       penable,
	input  logic                                       pwrite,
	input  logic [12:2]                                paddr,
	input  logic [`SMU_DATA_W-1:0]                     pwdata,
	input  logic [`SMU_PCS_MAX-1:0][`SMU_DATA_W-1:0]   pcs_rdata,
	input  logic [`SMU_RST_SRC_W-1:0]                  pcs0_reset_source,
	output logic [`SMU_DATA_W-1:0]                     prdata,
	output logic                                       pready,
	output logic                                       pslverr,
	output smu_pkg::pcs_req_t                          pcs_req,
	output logic                                       smu_sw_rst,
	output logic [`SMU_CLKR_W-1:0]                     system_clock_ratio,
	output logic [`SMU_CER_W-1:0]                      clk_en,
	output smu_pkg::hart_vecs_t                        core_reset_vectors
);
	import smu_pkg::*;

	apb_req_t                   apb;
	reg_sel_t                   sel;
	reg_wr_t                    wr;
	sys_ctl_t                   sys_ctl;
	pcs_rd_t                    pcs_rd;
	logic [`SMU_RST_SRC_W-1:0]  wakeup_st;

	assign apb = '{psel: psel, penable: penable, pwrite: pwrite, waddr: paddr, wdata: pwdata};

	smu_apb_decode #(.NHART(NHART)) u_decode (
		.apb       (apb),
		.sys_ctl   (sys_ctl),
		.wakeup_st (wakeup_st),
		.hart_vecs (core_reset_vectors),
		.pcs_rd    (pcs_rd),
		.sel       (sel),
		.wr        (wr),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr)
	);

	smu_sys_regs u_sys_regs (
		.pclk               (pclk),
		.apor_rstn          (apor_rstn),
		.sel                (sel),
		.wr                 (wr),
		.sys_ctl            (sys_ctl),
		.system_clock_ratio (system_clock_ratio),
		.clk_en             (clk_en),
		.smu_sw_rst         (smu_sw_rst)
	);

	smu_reset_status u_reset_status (
		.pclk              (pclk),
		.apor_rstn         (apor_rstn),
		.sel               (sel),
		.wr                (wr),
		.pcs0_reset_source (pcs0_reset_source),
		.wakeup_st         (wakeup_st)
	);

	smu_rst_vec_regs #(.NHART(NHART)) u_rst_vec_regs (
		.pclk      (pclk),
		.apor_rstn (apor_rstn),
		.sel       (sel),
		.wr        (wr),
		.hart_vecs (core_reset_vectors)     // Direct to the harts
	);

	smu_pcs_port #(.PCS_NUM(PCS_NUM)) u_pcs_port (
		.apb       (apb),
		.pcs_rdata (pcs_rdata),
		.pcs_req   (pcs_req),
		.pcs_rd    (pcs_rd)
	);

endmodule

// ==== smu_pcs_port.sv ====
`timescale 1ns/1ps
`include "smu_defs.svh"

module smu_pcs_port #(
	parameter int PCS_NUM = 8                           // 1 ~ 8
) (
	input  smu_pkg::apb_req_t                                  apb,
	input  logic [`SMU_PCS_MAX-1:0][`SMU_DATA_W-1:0]           pcs_rdata,
	output smu_pkg::pcs_req_t                                  pcs_req,
	output smu_pkg::pcs_rd_t                                   pcs_rd
);
	import smu_pkg::*;

	logic [7:0] win_base [`SMU_PCS_MAX];                // paddr[12:5] per window

	always_comb begin
		for (int k = 0; k < `SMU_PCS_MAX; k++) begin
			win_base[k] = (k < 4) ? `SMU_PCS_LO_BASE + 8'(k) : `SMU_PCS_HI_BASE + 8'(k - 4);
		end
	end

	// ====================
	// Request and read-back
	// ====================
	always_comb begin
		pcs_req.sel     = '0;
		pcs_req.write   = apb.psel & apb.penable & apb.pwrite;  // Not window gated
		pcs_req.reg_idx = pcs_reg_e'(apb.waddr[2:0]);
		pcs_req.wdata   = apb.wdata;
		pcs_rd.rdata    = '0;
		for (int k = 0; k < `SMU_PCS_MAX; k++) begin
			pcs_req.sel[k] = apb.psel && (k < PCS_NUM) && (apb.waddr[10:3] == win_base[k]);
			pcs_rd.rdata  |= {32{pcs_req.sel[k]}} & pcs_rdata[k];
		end
		pcs_rd.hit = |pcs_req.sel;
	end

endmodule

// ==== smu_rst_vec_regs.sv ====
`timescale 1ns/1ps
`include "smu_defs.svh"

module smu_rst_vec_regs #(
	parameter int NHART = 1                             // 1 ~ 4
) (
	input  logic                  pclk,
	input  logic                  apor_rstn,
	input  smu_pkg::reg_sel_t     sel,
	input  smu_pkg::reg_wr_t      wr,
	output smu_pkg::hart_vecs_t   hart_vecs
);

	localparam logic [31:0] LO_DEFAULT = `SMU_RST_VEC_LO_DEFAULT;
	localparam logic [31:0] HI_DEFAULT = `SMU_RST_VEC_HI_DEFAULT;

	for (genvar i = 0; i < `SMU_NHART_MAX; i++) begin : g_hart
		if (i < NHART) begin : g_on
			logic [31:2] lo_q;                      // Word aligned
			logic [31:0] hi_q;

			always_ff @(posedge pclk or negedge apor_rstn) begin
				if (!apor_rstn) begin
					lo_q <= LO_DEFAULT[31:2];
					hi_q <= HI_DEFAULT;
				end else begin
					if (wr.wen & sel.vec_lo[i]) begin
						lo_q <= wr.wdata[31:2];
					end
					if (wr.wen & sel.vec_hi[i]) begin
						hi_q <= wr.wdata;
					end
				end
			end

			assign hart_vecs[i] = {hi_q, lo_q, 2'b00};
		end else begin : g_off
			assign hart_vecs[i] = '0;               // Hart not present
		end
	end

endmodule

// ==== smu_reset_status.sv ====
`timescale 1ns/1ps
`include "smu_defs.svh"

module smu_reset_status (
	input  logic                         pclk,
	input  logic                         apor_rstn,
	input  smu_pkg::reg_sel_t            sel,
	input  smu_pkg::reg_wr_t             wr,
	input  logic [`SMU_RST_SRC_W-1:0]    pcs0_reset_source,
	output logic [`SMU_RST_SRC_W-1:0]    wakeup_st
);
	import smu_pkg::*;

	// Only the always-on bit comes up set
	localparam logic [`SMU_RST_SRC_W-1:0] ST_RESET = `SMU_RST_SRC_W'(1) << APOR;

	logic [`SMU_RST_SRC_W-1:0] st_q;
	logic [`SMU_RST_SRC_W-1:0] st_clr;
	logic [`SMU_RST_SRC_W-1:0] st_nx;

	assign st_clr = {`SMU_RST_SRC_W{wr.wen & sel.wakeupst}} & wr.wdata[`SMU_RST_SRC_W-1:0];
	assign st_nx  = pcs0_reset_source | (st_q & ~st_clr);   // Set wins

	always_ff @(posedge pclk or negedge apor_rstn) begin
		if (!apor_rstn) begin
			st_q <= ST_RESET;
		end else begin
			st_q <= st_nx;
		end
	end

	assign wakeup_st = st_q;

endmodule

// ==== smu_sys_regs.sv ====
`timescale 1ns/1ps
`include "smu_defs.svh"

module smu_sys_regs (
	input  logic                      pclk,
	input  logic                      apor_rstn,
	input  smu_pkg::reg_sel_t         sel,
	input  smu_pkg::reg_wr_t          wr,
	output smu_pkg::sys_ctl_t         sys_ctl,
	output logic [`SMU_CLKR_W-1:0]    system_clock_ratio,
	output logic [`SMU_CER_W-1:0]     clk_en,
	output logic                      smu_sw_rst
);

	logic [`SMU_CLKR_W-1:0] clkr_q;
	logic [`SMU_CER_W-1:0]  cer_q;
	logic                   sw_rst_q;
	logic                   sw_rst_cmd;

	// Key must match the low byte
	assign sw_rst_cmd = wr.wen & sel.smucr & (wr.wdata[7:0] == `SMU_SW_RST_KEY);

	// ====================
	// Control registers
	// ====================
	always_ff @(posedge pclk or negedge apor_rstn) begin
		if (!apor_rstn) begin
			clkr_q   <= `SMU_CLKR_DEFAULT;
			cer_q    <= `SMU_CER_DEFAULT;
			sw_rst_q <= 1'b0;
		end else begin
			if (wr.wen & sel.systemcr) begin
				clkr_q <= wr.wdata[`SMU_CLKR_W-1:0];
			end
			if (wr.wen & sel.clken) begin
				cer_q <= wr.wdata[`SMU_CER_W-1:0];
			end
			sw_rst_q <= sw_rst_cmd & ~sw_rst_q;      // No re-arm while high
		end
	end

	assign sys_ctl            = '{clkr: clkr_q, cer: cer_q};
	assign system_clock_ratio = clkr_q;
	assign clk_en             = cer_q;
	assign smu_sw_rst         = sw_rst_q;

endmodule

// ==== smu_apb_decode.sv ====
`timescale 1ns/1ps
`include "smu_defs.svh"

module smu_apb_decode #(
	parameter int NHART = 1                             // 1 ~ 4
) (
	input  smu_pkg::apb_req_t            apb,
	input  smu_pkg::sys_ctl_t            sys_ctl,
	input  logic [`SMU_RST_SRC_W-1:0]    wakeup_st,
	input  smu_pkg::hart_vecs_t          hart_vecs,
	input  smu_pkg::pcs_rd_t             pcs_rd,
	output smu_pkg::reg_sel_t            sel,
	output smu_pkg::reg_wr_t             wr,
	output logic [`SMU_DATA_W-1:0]       prdata,
	output logic                         pready,
	output logic                         pslverr
);
	import smu_pkg::*;

	localparam logic [7:0]  CORE_NUM     = 8'(NHART);
	localparam logic [31:0] SR_SYSTEMVER = `SMU_PRODUCT_ID;
	localparam logic [31:0] SR_BOARDID   = `SMU_BOARD_ID;
	localparam logic [31:0] SR_SMUVER    = `SMU_VERID;
	localparam logic [31:0] SR_SYSTEMTS  = `SMU_SYS_TS;
	localparam logic [31:0] SR_SYSTEMCFG = 32'({`SMU_L2C_PRESENT, CORE_NUM});

	logic [`SMU_DATA_W-1:0] vec_rdata;

	// ====================
	// Word decode
	// ====================
	always_comb begin
		sel           = '0;
		sel.systemver = (apb.waddr == SYSTEMVER);
		sel.boardid   = (apb.waddr == BOARDID);
		sel.systemcfg = (apb.waddr == SYSTEMCFG);
		sel.smuver    = (apb.waddr == SMUVER);
		sel.wakeupst  = (apb.waddr == WAKEUPST);
		sel.smucr     = (apb.waddr == SMUCR);
		sel.clken     = (apb.waddr == CLKEN);
		sel.systemcr  = (apb.waddr == SYSTEMCR);
		sel.systemts  = (apb.waddr == SYSTEMTS);
		for (int i = 0; i < NHART && i < `SMU_NHART_MAX; i++) begin
			sel.vec_lo[i] = (apb.waddr == 11'(VEC_LO0 + i));   // Absent harts stay 0
			sel.vec_hi[i] = (apb.waddr == 11'(VEC_HI0 + i));
		end
	end

	assign wr.wen   = apb.psel & apb.penable & apb.pwrite;
	assign wr.wdata = apb.wdata;

	// ====================
	// Read mux
	// ====================
	always_comb begin
		vec_rdata = '0;
		for (int i = 0; i < `SMU_NHART_MAX; i++) begin
			vec_rdata |= {32{sel.vec_lo[i]}} & hart_vecs[i][31:0];
			vec_rdata |= {32{sel.vec_hi[i]}} & hart_vecs[i][63:32];
		end
	end

	// Valid in both setup and access phase
	assign prdata = ({32{sel.systemver}} & SR_SYSTEMVER)
		| ({32{sel.boardid}}   & SR_BOARDID)
		| ({32{sel.systemcfg}} & SR_SYSTEMCFG)
		| ({32{sel.smuver}}    & SR_SMUVER)
		| ({32{sel.systemts}}  & SR_SYSTEMTS)
		| ({32{sel.wakeupst}}  & 32'(wakeup_st))
		| ({32{sel.systemcr}}  & 32'(sys_ctl.clkr))
		| ({32{sel.clken}}     & 32'(sys_ctl.cer))
		| vec_rdata
		| ({32{pcs_rd.hit}}    & pcs_rd.rdata);

	assign pready  = 1'b1;                              // Zero wait
	assign pslverr = 1'b0;

endmodule

// ==== smu_pkg.sv ====
`include "smu_defs.svh"

package smu_pkg;

	// ====================
	// Bus structs
	// ====================
	typedef struct packed {
		logic                      psel;
		logic                      penable;
		logic                      pwrite;
		logic [`SMU_WADDR_W-1:0]   waddr;   // paddr[12:2]
		logic [`SMU_DATA_W-1:0]    wdata;
	} apb_req_t;

	// Register word index, paddr[12:2]
	typedef enum logic [`SMU_WADDR_W-1:0] {
		SYSTEMVER = 11'h00,
		BOARDID   = 11'h01,
		SYSTEMCFG = 11'h02,
		SMUVER    = 11'h03,
		WAKEUPST  = 11'h04,
		SMUCR     = 11'h05,
		CLKEN     = 11'h08,
		SYSTEMCR  = 11'h09,
		VEC_LO0   = 11'h14,
		VEC_LO1   = 11'h15,
		VEC_LO2   = 11'h16,
		VEC_LO3   = 11'h17,
		VEC_HI0   = 11'h18,
		VEC_HI1   = 11'h19,
		VEC_HI2   = 11'h1a,
		VEC_HI3   = 11'h1b,
		SYSTEMTS  = 11'h1c
	} smu_reg_e;

	typedef struct packed {
		logic                        systemver;
		logic                        boardid;
		logic                        systemcfg;
		logic                        smuver;
		logic                        wakeupst;
		logic                        smucr;
		logic                        clken;
		logic                        systemcr;
		logic                        systemts;
		logic [`SMU_NHART_MAX-1:0]   vec_lo;
		logic [`SMU_NHART_MAX-1:0]   vec_hi;
	} reg_sel_t;

	typedef struct packed {
		logic                      wen;     // psel & penable & pwrite
		logic [`SMU_DATA_W-1:0]    wdata;
	} reg_wr_t;

	typedef struct packed {
		logic [`SMU_CLKR_W-1:0]    clkr;
		logic [`SMU_CER_W-1:0]     cer;
	} sys_ctl_t;

	// PCS register index, paddr[4:2]
	typedef enum logic [2:0] {
		CFG     = 3'd0,
		SCRATCH = 3'd1,
		MISC    = 3'd2,
		MISC2   = 3'd3,
		WE      = 3'd4,
		CTL     = 3'd5,
		STATUS  = 3'd6,
		CER     = 3'd7
	} pcs_reg_e;

	typedef struct packed {
		logic [`SMU_PCS_MAX-1:0]   sel;     // One-hot window select
		logic                      write;
		pcs_reg_e                  reg_idx;
		logic [`SMU_DATA_W-1:0]    wdata;
	} pcs_req_t;

	typedef struct packed {
		logic                      hit;
		logic [`SMU_DATA_W-1:0]    rdata;
	} pcs_rd_t;

	// Reset source and status bit positions
	typedef enum logic [2:0] {
		APOR = 3'd0,
		SW   = 3'd1,
		WDT  = 3'd2,
		HW   = 3'd3,
		MPOR = 3'd4
	} rst_src_e;

	// Hart 0 in bits 63:0
	typedef logic [`SMU_NHART_MAX-1:0][63:0] hart_vecs_t;

endpackage

// ==== smu_defs.svh ====
`ifndef SMU_DEFS_SVH
`define SMU_DEFS_SVH

// ====================
// Widths
// ====================
`define SMU_DATA_W              32
`define SMU_WADDR_W             11      // paddr[12:2]
`define SMU_NHART_MAX           4
`define SMU_PCS_MAX             8
`define SMU_CLKR_W              5
`define SMU_CER_W               3
`define SMU_RST_SRC_W           5

// PCS window bases as paddr[12:5]
`define SMU_PCS_LO_BASE         8'h04   // Windows 0-3 from 0x80
`define SMU_PCS_HI_BASE         8'h08   // Windows 4-7 from 0x100

// ====================
// Ids and defaults
// ====================
`define SMU_PRODUCT_ID          32'h0350_0001
`define SMU_BOARD_ID            32'h0000_0a01
`define SMU_VERID               32'h0001_0000
`define SMU_SYS_TS              32'h0000_5a5a
`define SMU_L2C_PRESENT         1'b0
`define SMU_CLKR_DEFAULT        5'h01
`define SMU_CER_DEFAULT         3'h7
`define SMU_RST_VEC_LO_DEFAULT  32'h8000_0000
`define SMU_RST_VEC_HI_DEFAULT  32'h0000_0000
`define SMU_SW_RST_KEY          8'h3c

`endif
